// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := vec_decode_stage_tb
FILELIST  := compile.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: bench/vec_decode_stage_assertions.sv
/*
 * decode stage checks
 * counter hold under stall, counter stop after the last pair and
 * the latch valid flag after flush
 */
`default_nettype none

module vec_decode_stage_assertions (
  input logic        CLK,
  input logic        nRST,
  input logic        start,
  input logic        stall,
  input logic        flush,
  input logic        done,
  input logic        active,
  input logic        ex_valid,
  input logic [31:0] offset
);

  hold_offset: assert property (@(posedge CLK) disable iff (!nRST)
    active && stall && !flush && !start |=> $stable(offset))
    else $error("element offset moved while stalled");

  // last pair leaves the counter
  stop_after_done: assert property (@(posedge CLK) disable iff (!nRST)
    done && !stall && !flush && !start |=> !active)
    else $error("counter still active after its last pair");

  flush_clears_valid: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !ex_valid)
    else $error("ex_valid high the cycle after flush");

endmodule

`default_nettype wire

// File: bench/vec_decode_stage_tb.sv
/*
 * vector decode stage testbench
 * random and swept instructions with random stall and mask, flush runs,
 * reference model for every decoded pair and a watchdog
 */
`default_nettype none

module vec_decode_stage_tb
  import vec_decode_pkg::*;
();

  localparam int VLEN        = 128;
  localparam int WHOLE_ELEMS = VLEN / 32;
  localparam int RAND_RUNS   = 40;
  localparam int MAX_VL      = 20;
  localparam int RUNS        = 54 + 2 + RAND_RUNS;
  localparam int TIMEOUT     = RUNS * ((MAX_VL / 2) * 4 + 10) * 4;

  logic       CLK, nRST, v_start, stall, flush;
  vinstr_u    instr;
  sew_t       vtype_sew;
  vlmul_t     vtype_lmul;
  offset_t    vl, vstart;
  word_t      xs1;
  logic [1:0] mask_bits;
  logic       ex_valid, ex_wen0, ex_wen1, ex_load, ex_store, ex_done, busy;
  offset_t    ex_woffset0, ex_woffset1, ex_vs2_offset0, ex_vs2_offset1, ex_elem_count;
  logic [4:0] ex_vd;
  aluop_t     ex_aluop;
  vlmul_t     ex_emul;
  word_t      ex_vs1_identity, ex_imm;

  // expected decode of the instruction in flight
  aluop_t     e_aluop;
  vs2_src_t   e_src;
  logic       e_red, e_load, e_store, e_whole, e_vm, e_opv;
  logic [4:0] e_vd;
  word_t      e_imm;
  vlmul_t     e_emul;
  offset_t    e_count;
  offset_t    exp_idx;
  int         pairs;
  int         errors = 0;
  logic       run_over = 1'b0;
  logic       flushed = 1'b0;
  logic [31:0] seed = 32'h1fcd_e4e4;

  vlmul_t lmuls[6]  = '{LMULFOURTH, LMULHALF, LMUL1, LMUL2, LMUL4, LMUL8};
  width_t widths[3] = '{WIDTH8, WIDTH16, WIDTH32};
  sew_t   sews[3]   = '{SEW8, SEW16, SEW32};

  vec_decode_stage #(.VLEN(VLEN)) vec_decode_stage_i (.*);

  bind vec_decode_stage vec_decode_stage_assertions asrt_i (
    .CLK(CLK), .nRST(nRST), .start(v_start), .stall(stall), .flush(flush),
    .done(done), .active(active), .ex_valid(ex_valid), .offset(offset)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic logic [31:0] rnd();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int lmul_log2(vlmul_t l);
    case (l)
      LMULFOURTH: return -2;
      LMULHALF:   return -1;
      LMUL2:      return 1;
      LMUL4:      return 2;
      LMUL8:      return 3;
      default:    return 0;
    endcase
  endfunction

  // EMUL is eew/sew times lmul clamped to 1/4 .. 8
  function automatic vlmul_t emul_ref(sew_t s, vlmul_t l, width_t w, logic ls);
    int e;
    if (!ls) return l;
    e = lmul_log2(l) + (w == WIDTH16 ? 1 : w == WIDTH32 ? 2 : 0) -
        (s == SEW16 ? 1 : s == SEW32 ? 2 : 0);
    if (e <= -2) return LMULFOURTH;
    if (e >= 3) return LMUL8;
    return lmuls[e + 2];
  endfunction

  function automatic word_t identity_ref(aluop_t op);
    case (op)
      VALU_AND, VALU_MINU: return 32'hffff_ffff;
      VALU_MIN:            return 32'h7fff_ffff;
      VALU_MAX:            return 32'h8000_0000;
      default:             return 32'h0;
    endcase
  endfunction

  // expected vs2 offsets and enables of the pair at idx
  function automatic void pair_ref(input offset_t idx, input logic [1:0] m,
                                   output offset_t v0, output offset_t v1,
                                   output logic w0, output logic w1);
    offset_t base;
    case (e_src)
      VS2_SRC_IDX_PLUS_RS1:  base = idx + xs1;
      VS2_SRC_IDX_PLUS_UIMM: base = idx + {27'd0, e_imm[4:0]};
      VS2_SRC_IDX_PLUS_1:    base = idx + 32'd1;
      default:               base = idx;
    endcase
    v0 = (e_src == VS2_SRC_ZERO) ? 32'd0 : base;
    v1 = (e_src == VS2_SRC_ZERO) ? 32'd0 : base + 32'd1;
    w0 = idx < vl && vstart < vl && !e_store && (e_vm || m[0]);
    w1 = idx + 32'd1 < vl && vstart < vl && !e_store && (e_vm || m[1]) && !e_red;
  endfunction

  // looks at the pair captured on each rising edge
  initial begin
    logic s, f, st, w0, w1, last;
    logic cnt_active;
    logic [1:0] m;
    offset_t v0, v1;
    cnt_active = 1'b0;
    forever begin
      @(posedge CLK);
      s  = stall;
      f  = flush;
      st = v_start;
      m  = mask_bits;
      @(negedge CLK);
      if (st) flushed = 1'b0;
      if (!nRST) begin
        cnt_active = 1'b0;
        check_val("ex_valid in reset", 32'(ex_valid), 32'd0);
      end else if (f) begin
        cnt_active = 1'b0;
        flushed    = 1'b1;
        run_over   = 1'b1;
      end else if (flushed) begin
        check_val("ex_valid after flush", 32'(ex_valid), 32'd0);
      end else if (!s) begin
        // a pair leaves the counter on each unstalled edge while it is active
        check_val("ex_valid", 32'(ex_valid), 32'(cnt_active));
        if (cnt_active) begin
          pair_ref(exp_idx, m, v0, v1, w0, w1);
          last = exp_idx + 32'd2 >= e_count;
          check_val("ex_woffset0", ex_woffset0, exp_idx);
          check_val("ex_woffset1", ex_woffset1, exp_idx + 32'd1);
          check_val("ex_vs2_offset0", ex_vs2_offset0, v0);
          check_val("ex_vs2_offset1", ex_vs2_offset1, v1);
          check_val("ex_wen0", 32'(ex_wen0), 32'(w0));
          check_val("ex_wen1", 32'(ex_wen1), 32'(w1));
          check_val("ex_vd", 32'(ex_vd), 32'(e_vd));
          check_val("ex_emul", 32'(ex_emul), 32'(e_emul));
          check_val("ex_elem_count", ex_elem_count, e_count);
          check_val("ex_load", 32'(ex_load), 32'(e_load));
          check_val("ex_store", 32'(ex_store), 32'(e_store));
          check_val("ex_done", 32'(ex_done), 32'(last));
          if (e_opv) begin
            check_val("ex_aluop", 32'(ex_aluop), 32'(e_aluop));
            check_val("ex_imm", ex_imm, e_imm);
          end
          if (e_red) check_val("ex_vs1_identity", ex_vs1_identity, identity_ref(e_aluop));
          if (last) begin
            run_over   = 1'b1;
            cnt_active = 1'b0;
          end
          exp_idx += 32'd2;
          pairs++;
        end
      end
      // counter goes active on the v_start edge
      if (nRST && !f && st) cnt_active = 1'b1;
      check_val("busy", 32'(busy), 32'(v_start || cnt_active));
    end
  end

  // starts at 1 unit after a rising edge and returns at the same phase
  task automatic run_instr(input logic [31:0] word, input logic stalls, input logic do_flush);
    logic [31:0] r;
    instr    = word;
    v_start  = 1'b1;
    stall    = 1'b0;
    flush    = 1'b0;
    exp_idx  = vstart;
    pairs    = 0;
    run_over = 1'b0;
    @(posedge CLK);
    #1 v_start = 1'b0;
    while (!run_over) begin
      r         = rnd();
      stall     = stalls && r[3:2] == 2'b00;
      mask_bits = r[1:0];
      flush     = do_flush && pairs >= 2;
      @(posedge CLK);
      #1;
    end
    stall = 1'b0;
    flush = 1'b0;
    if (!do_flush) check_val("pair count", 32'(pairs), (e_count - vstart + 32'd1) / 32'd2);
    repeat (do_flush ? 4 : 2) @(posedge CLK);
    #1;
  endtask

  function automatic logic [31:0] mk_arith(logic [5:0] f6, logic m, logic [4:0] v1,
                                           logic [2:0] f3, logic [4:0] d);
    return {f6, m, 5'd2, v1, f3, d, OPCODE_OPV};
  endfunction

  function automatic logic [31:0] mk_ls(logic [6:0] op, logic m, logic [4:0] lumop,
                                        width_t w, logic [4:0] d);
    return {3'b000, 1'b0, 2'b00, m, lumop, 5'd1, w, d, op};
  endfunction

  task automatic clear_expect(input logic m, input logic [4:0] d);
    e_aluop = VALU_ADD;
    e_src   = VS2_SRC_NORMAL;
    e_red   = 1'b0;
    e_load  = 1'b0;
    e_store = 1'b0;
    e_whole = 1'b0;
    e_opv   = 1'b0;
    e_vm    = m;
    e_vd    = d;
  endtask

  task automatic emul_test(input sew_t s, input vlmul_t l, input width_t w);
    clear_expect(1'b1, 5'd8);
    e_load     = 1'b1;
    vtype_sew  = s;
    vtype_lmul = l;
    vl         = 32'd2;
    vstart     = 32'd0;
    e_count    = vl;
    e_emul     = emul_ref(s, l, w, 1'b1);
    run_instr(mk_ls(OPCODE_VLOAD, 1'b1, 5'd0, w, 5'd8), 1'b0, 1'b0);
  endtask

  task automatic random_test(input logic do_flush);
    logic [31:0] r;
    logic [5:0]  f6;
    logic [2:0]  f3;
    logic [4:0]  v1;
    logic [31:0] word;
    width_t      w;
    int          kind;
    r          = rnd();
    kind       = do_flush ? 0 : int'(r % 32'd12);
    clear_expect(r[8], r[13:9]);
    v1         = r[18:14];
    w          = widths[rnd() % 32'd3];
    vtype_sew  = sews[rnd() % 32'd3];
    vtype_lmul = lmuls[rnd() % 32'd6];
    vl         = do_flush ? 32'd16 : 32'd1 + rnd() % MAX_VL;
    xs1        = rnd() % 32'd8;
    f6         = 6'b000000;
    f3         = 3'b000;
    e_opv      = kind < 9;
    case (kind)
      1: f3 = 3'b011;
      2: begin
        f6      = 6'b001001;
        e_aluop = VALU_AND;
      end
      3: begin
        f6      = 6'b000111;
        f3      = 3'b100;
        e_aluop = VALU_MAX;
      end
      4: begin
        f6      = 6'b001111;
        f3      = 3'b100;
        e_aluop = VALU_SLIDE;
        e_src   = VS2_SRC_IDX_PLUS_RS1;
      end
      5: begin
        f6      = 6'b001111;
        f3      = 3'b011;
        e_aluop = VALU_SLIDE;
        e_src   = VS2_SRC_IDX_PLUS_UIMM;
      end
      6: begin
        f6      = 6'b001100;
        e_aluop = VALU_SLIDE;
        e_src   = VS2_SRC_ZERO;
      end
      7: begin
        f6      = 6'b001111;
        f3      = 3'b110;
        e_aluop = VALU_SLIDE;
        e_src   = VS2_SRC_IDX_PLUS_1;
      end
      8: begin
        // single-width integer reductions
        f3    = 3'b010;
        e_red = 1'b1;
        case (rnd() % 32'd7)
          32'd1: begin
            f6      = 6'b000001;
            e_aluop = VALU_AND;
          end
          32'd2: begin
            f6      = 6'b000010;
            e_aluop = VALU_OR;
          end
          32'd3: begin
            f6      = 6'b000100;
            e_aluop = VALU_MINU;
          end
          32'd4: begin
            f6      = 6'b000101;
            e_aluop = VALU_MIN;
          end
          32'd5: begin
            f6      = 6'b000110;
            e_aluop = VALU_MAXU;
          end
          32'd6: begin
            f6      = 6'b000111;
            e_aluop = VALU_MAX;
          end
          default: f6 = 6'b000000;
        endcase
      end
      9:  e_load = 1'b1;
      10: begin
        e_load  = 1'b1;
        e_whole = 1'b1;
      end
      11: e_store = 1'b1;
      default: ;
    endcase
    // immediates are signed only for arithmetic .vi forms
    e_imm   = (f3 == 3'b011 && e_aluop != VALU_SLIDE) ? {{27{v1[4]}}, v1} : {27'd0, v1};
    e_count = e_whole ? WHOLE_ELEMS : vl;
    vstart  = do_flush ? 32'd0 : rnd() % e_count;
    e_emul  = emul_ref(vtype_sew, vtype_lmul, w, e_load || e_store);
    if (kind < 9) word = mk_arith(f6, e_vm, v1, f3, e_vd);
    else word = mk_ls(e_store ? OPCODE_VSTORE : OPCODE_VLOAD, e_vm,
                      e_whole ? LUMOP_WHOLE_REG : 5'd0, w, e_vd);
    run_instr(word, 1'b1, do_flush);
  endtask

  initial begin
    nRST       = 1'b0;
    instr      = '0;
    v_start    = 1'b0;
    vtype_sew  = SEW32;
    vtype_lmul = LMUL1;
    vl         = '0;
    vstart     = '0;
    xs1        = '0;
    mask_bits  = 2'b00;
    stall      = 1'b0;
    flush      = 1'b0;
    repeat (4) @(posedge CLK);
    #1 nRST = 1'b1;
    foreach (sews[s])
      foreach (lmuls[l])
        foreach (widths[w])
          emul_test(sews[s], lmuls[l], widths[w]);
    repeat (2) random_test(1'b1);
    repeat (RAND_RUNS) random_test(1'b0);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the test sequence did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/vec_decode_pkg.sv
hdl/vec_instr_decoder.sv
hdl/vec_emul_calc.sv
hdl/vec_element_counter.sv
hdl/vec_offset_gen.sv
hdl/vec_decode_latch.sv
hdl/vec_decode_stage.sv
bench/vec_decode_stage_assertions.sv
bench/vec_decode_stage_tb.sv

// File: hdl/vec_decode_latch.sv
/*
 * decode/execute register
 * captures one decoded element pair per cycle, holds under stall and
 * drops the valid and enable flags on flush
 */
`default_nettype none

module vec_decode_latch
  import vec_decode_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       stall,
  input  logic       flush,
  input  logic       valid,
  input  logic       done,
  input  logic       wen0,
  input  logic       wen1,
  input  logic       is_load,
  input  logic       is_store,
  input  offset_t    woffset0,
  input  offset_t    woffset1,
  input  offset_t    vs2_offset0,
  input  offset_t    vs2_offset1,
  input  logic [4:0] vd,
  input  aluop_t     aluop,
  input  vlmul_t     emul,
  input  offset_t    elem_count,
  input  word_t      identity,
  input  logic [4:0] imm5,
  input  logic       sign_imm,
  output logic       ex_valid,
  output logic       ex_done,
  output logic       ex_wen0,
  output logic       ex_wen1,
  output logic       ex_load,
  output logic       ex_store,
  output offset_t    ex_woffset0,
  output offset_t    ex_woffset1,
  output offset_t    ex_vs2_offset0,
  output offset_t    ex_vs2_offset1,
  output logic [4:0] ex_vd,
  output aluop_t     ex_aluop,
  output vlmul_t     ex_emul,
  output offset_t    ex_elem_count,
  output word_t      ex_vs1_identity,
  output word_t      ex_imm
);

  word_t imm_ext;

  assign imm_ext = sign_imm ? {{27{imm5[4]}}, imm5} : {27'd0, imm5};

  // control flags, flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid <= 1'b0;
      ex_done  <= 1'b0;
      ex_wen0  <= 1'b0;
      ex_wen1  <= 1'b0;
      ex_load  <= 1'b0;
      ex_store <= 1'b0;
    end else if (flush) begin
      ex_valid <= 1'b0;
      ex_done  <= 1'b0;
      ex_wen0  <= 1'b0;
      ex_wen1  <= 1'b0;
      ex_load  <= 1'b0;
      ex_store <= 1'b0;
    end else if (!stall) begin
      ex_valid <= valid;
      ex_done  <= done;
      ex_wen0  <= wen0 && valid;
      ex_wen1  <= wen1 && valid;
      ex_load  <= is_load && valid;
      ex_store <= is_store && valid;
    end
  end

  // pair payload
  always_ff @(posedge CLK) begin
    if (!stall) begin
      ex_woffset0     <= woffset0;
      ex_woffset1     <= woffset1;
      ex_vs2_offset0  <= vs2_offset0;
      ex_vs2_offset1  <= vs2_offset1;
      ex_vd           <= vd;
      ex_aluop        <= aluop;
      ex_emul         <= emul;
      ex_elem_count   <= elem_count;
      ex_vs1_identity <= identity;
      ex_imm          <= imm_ext;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vec_decode_pkg.sv
/*
 * vector decode package
 * shared encodings for the vector decode stage: element width, register
 * grouping, load/store width, operation class, vs2 offset source and the
 * instruction word with its arithmetic and load/store views
 */
`default_nettype none

package vec_decode_pkg;

  // vtype vsew encoding
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  // vtype vlmul encoding, read as a signed log2 of the grouping
  typedef enum logic [2:0] {
    LMUL1      = 3'b000,
    LMUL2      = 3'b001,
    LMUL4      = 3'b010,
    LMUL8      = 3'b011,
    LMULFOURTH = 3'b110,
    LMULHALF   = 3'b111
  } vlmul_t;

  // width field of vector loads and stores
  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

  typedef enum logic [3:0] {
    VALU_ADD   = 4'd0,
    VALU_AND   = 4'd1,
    VALU_OR    = 4'd2,
    VALU_MIN   = 4'd3,
    VALU_MINU  = 4'd4,
    VALU_MAX   = 4'd5,
    VALU_MAXU  = 4'd6,
    VALU_SLIDE = 4'd7
  } aluop_t;

  typedef enum logic [2:0] {
    VS2_SRC_NORMAL        = 3'd0,
    VS2_SRC_IDX_PLUS_RS1  = 3'd1,
    VS2_SRC_IDX_PLUS_UIMM = 3'd2,
    VS2_SRC_IDX_PLUS_1    = 3'd3,
    VS2_SRC_ZERO          = 3'd4
  } vs2_src_t;

  typedef logic [31:0] offset_t;
  typedef logic [31:0] word_t;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;      // vs1, rs1 or imm5 depending on funct3
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } arith_fmt_t;

  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] lumop;    // sumop for stores
    logic [4:0] rs1;
    width_t     width;
    logic [4:0] vd;       // vs3 for stores
    logic [6:0] opcode;
  } ls_fmt_t;

  typedef union packed {
    arith_fmt_t arith;
    ls_fmt_t    ls;
  } vinstr_u;

  localparam logic [6:0] OPCODE_VLOAD  = 7'b0000111;
  localparam logic [6:0] OPCODE_VSTORE = 7'b0100111;
  localparam logic [6:0] OPCODE_OPV    = 7'b1010111;

  localparam logic [4:0] LUMOP_WHOLE_REG = 5'b01000;

endpackage

`default_nettype wire

// File: hdl/vec_decode_stage.sv
/*
 * vector decode stage
 * decodes one vector instruction and streams its element pairs into the
 * decode/execute register, two lanes per cycle
 */
`default_nettype none

module vec_decode_stage
  import vec_decode_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic       CLK,
  input  logic       nRST,
  input  vinstr_u    instr,
  input  logic       v_start,
  input  sew_t       vtype_sew,
  input  vlmul_t     vtype_lmul,
  input  offset_t    vl,
  input  offset_t    vstart,
  input  word_t      xs1,
  input  logic [1:0] mask_bits,
  input  logic       stall,
  input  logic       flush,
  output logic       ex_valid,
  output logic       ex_wen0,
  output logic       ex_wen1,
  output offset_t    ex_woffset0,
  output offset_t    ex_woffset1,
  output offset_t    ex_vs2_offset0,
  output offset_t    ex_vs2_offset1,
  output logic [4:0] ex_vd,
  output aluop_t     ex_aluop,
  output logic       ex_load,
  output logic       ex_store,
  output vlmul_t     ex_emul,
  output offset_t    ex_elem_count,
  output word_t      ex_vs1_identity,
  output word_t      ex_imm,
  output logic       ex_done,
  output logic       busy
);

  logic       is_load, is_store, whole_reg, reduction, vm, sign_imm;
  width_t     eew;
  aluop_t     aluop;
  vs2_src_t   vs2_src;
  logic [4:0] vd, imm5;
  vlmul_t     emul;
  offset_t    elem_count, offset;
  logic       active, done, wen0, wen1;
  offset_t    woffset0, woffset1, vs2_offset0, vs2_offset1;
  word_t      identity;

  vec_instr_decoder u_decoder (
    .instr(instr), .is_load(is_load), .is_store(is_store), .whole_reg(whole_reg),
    .eew(eew), .aluop(aluop), .reduction(reduction), .vs2_src(vs2_src),
    .vm(vm), .vd(vd), .imm5(imm5), .sign_imm(sign_imm)
  );

  vec_emul_calc #(.VLEN(VLEN)) u_emul (
    .sew(vtype_sew), .lmul(vtype_lmul), .eew(eew), .is_load(is_load),
    .is_store(is_store), .whole_reg(whole_reg), .vl(vl),
    .emul(emul), .elem_count(elem_count)
  );

  vec_element_counter u_counter (
    .CLK(CLK), .nRST(nRST), .start(v_start), .stall(stall), .flush(flush),
    .vstart(vstart), .elem_count(elem_count), .offset(offset),
    .active(active), .done(done), .busy(busy)
  );

  vec_offset_gen u_offsets (
    .offset(offset), .vl(vl), .vstart(vstart), .xs1(xs1), .imm5(imm5),
    .vs2_src(vs2_src), .vm(vm), .is_store(is_store), .reduction(reduction),
    .aluop(aluop), .mask_bits(mask_bits), .woffset0(woffset0), .woffset1(woffset1),
    .vs2_offset0(vs2_offset0), .vs2_offset1(vs2_offset1),
    .wen0(wen0), .wen1(wen1), .identity(identity)
  );

  vec_decode_latch u_latch (
    .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush),
    .valid(active), .done(done), .wen0(wen0), .wen1(wen1),
    .is_load(is_load), .is_store(is_store), .woffset0(woffset0), .woffset1(woffset1),
    .vs2_offset0(vs2_offset0), .vs2_offset1(vs2_offset1), .vd(vd), .aluop(aluop),
    .emul(emul), .elem_count(elem_count), .identity(identity), .imm5(imm5),
    .sign_imm(sign_imm), .ex_valid(ex_valid), .ex_done(ex_done),
    .ex_wen0(ex_wen0), .ex_wen1(ex_wen1), .ex_load(ex_load), .ex_store(ex_store),
    .ex_woffset0(ex_woffset0), .ex_woffset1(ex_woffset1),
    .ex_vs2_offset0(ex_vs2_offset0), .ex_vs2_offset1(ex_vs2_offset1),
    .ex_vd(ex_vd), .ex_aluop(ex_aluop), .ex_emul(ex_emul),
    .ex_elem_count(ex_elem_count), .ex_vs1_identity(ex_vs1_identity), .ex_imm(ex_imm)
  );

endmodule

`default_nettype wire

// File: hdl/vec_element_counter.sv
/*
 * element pair counter
 * walks the element index two lanes per cycle from vstart up to the
 * element count, with stall hold and flush
 */
`default_nettype none

module vec_element_counter
  import vec_decode_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    start,
  input  logic    stall,
  input  logic    flush,
  input  offset_t vstart,
  input  offset_t elem_count,
  output offset_t offset,
  output logic    active,
  output logic    done,
  output logic    busy
);

  logic [32:0] next_pair;

  // 33 bits so the compare survives indices near the top of the range
  assign next_pair = {1'b0, offset} + 33'd2;
  assign done      = active && next_pair >= {1'b0, elem_count};
  assign busy      = start || active;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active <= 1'b0;
      offset <= '0;
    end else if (flush) begin
      active <= 1'b0;
    end else if (start) begin
      active <= 1'b1;
      offset <= vstart;
    end else if (active && !stall) begin
      // last pair leaves the counter
      if (done) active <= 1'b0;
      offset <= next_pair[31:0];
    end
  end

endmodule

`default_nettype wire

// File: hdl/vec_emul_calc.sv
/*
 * EMUL and element count
 * scales the register grouping by eew/sew for loads and stores and picks
 * the number of elements this instruction walks
 */
`default_nettype none

module vec_emul_calc
  import vec_decode_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  sew_t    sew,
  input  vlmul_t  lmul,
  input  width_t  eew,
  input  logic    is_load,
  input  logic    is_store,
  input  logic    whole_reg,
  input  offset_t vl,
  output vlmul_t  emul,
  output offset_t elem_count
);

  // one register of 32-bit elements
  localparam offset_t WHOLE_REG_ELEMS = offset_t'(VLEN / 32);

  logic signed [3:0] lmul_log;
  logic signed [3:0] eew_log;
  logic signed [3:0] sew_log;
  logic signed [3:0] emul_log;

  // log2 arithmetic, vlmul is already a signed exponent
  assign lmul_log = {lmul[2], lmul};
  assign sew_log  = {2'b00, sew};

  always_comb begin
    case (eew)
      WIDTH16: eew_log = 4'sd1;
      WIDTH32: eew_log = 4'sd2;
      default: eew_log = 4'sd0;
    endcase
  end

  assign emul_log = lmul_log + eew_log - sew_log;

  always_comb begin
    if (!(is_load || is_store)) emul = lmul;
    else if (emul_log < -4'sd2) emul = LMULFOURTH;
    else if (emul_log > 4'sd3) emul = LMUL8;
    else emul = vlmul_t'(emul_log[2:0]);
  end

  assign elem_count = whole_reg ? WHOLE_REG_ELEMS : vl;

endmodule

`default_nettype wire

// File: hdl/vec_instr_decoder.sv
/*
 * vector instruction decoder
 * splits the instruction word into load/store or arithmetic control fields
 */
`default_nettype none

module vec_instr_decoder
  import vec_decode_pkg::*;
(
  input  vinstr_u    instr,
  output logic       is_load,
  output logic       is_store,
  output logic       whole_reg,
  output width_t     eew,
  output aluop_t     aluop,
  output logic       reduction,
  output vs2_src_t   vs2_src,
  output logic       vm,
  output logic [4:0] vd,
  output logic [4:0] imm5,
  output logic       sign_imm
);

  // funct3 categories
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPMVX = 3'b110;

  logic       is_opv;
  logic       opi;
  logic [5:0] f6;
  logic [2:0] f3;

  // load/store view
  assign is_load   = instr.ls.opcode == OPCODE_VLOAD;
  assign is_store  = instr.ls.opcode == OPCODE_VSTORE;
  assign whole_reg = (is_load || is_store) && instr.ls.mop == 2'b00 &&
                     instr.ls.lumop == LUMOP_WHOLE_REG;
  assign eew       = instr.ls.width;

  // arithmetic view, vm and vd share their bits with the load/store view
  assign is_opv = instr.arith.opcode == OPCODE_OPV;
  assign f6     = instr.arith.funct6;
  assign f3     = instr.arith.funct3;
  assign opi    = f3 == OPIVV || f3 == OPIVX || f3 == OPIVI;
  assign vm     = instr.arith.vm;
  assign vd     = instr.arith.vd;
  assign imm5   = instr.arith.vs1;

  always_comb begin
    aluop     = VALU_ADD;
    reduction = 1'b0;
    vs2_src   = VS2_SRC_NORMAL;
    if (is_opv && opi) begin
      case (f6)
        6'b001001: aluop = VALU_AND;
        6'b001010: aluop = VALU_OR;
        6'b000100: aluop = VALU_MINU;
        6'b000101: aluop = VALU_MIN;
        6'b000110: aluop = VALU_MAXU;
        6'b000111: aluop = VALU_MAX;
        // vslidedown reads vs2 ahead by the slide amount
        6'b001111: begin
          aluop   = VALU_SLIDE;
          vs2_src = (f3 == OPIVI) ? VS2_SRC_IDX_PLUS_UIMM : VS2_SRC_IDX_PLUS_RS1;
        end
        // vrgather, element 0 broadcast
        6'b001100: begin
          aluop   = VALU_SLIDE;
          vs2_src = VS2_SRC_ZERO;
        end
        default: aluop = VALU_ADD;
      endcase
    end else if (is_opv && f3 == OPMVV) begin
      // single-width integer reductions
      reduction = f6[5:3] == 3'b000 && f6[2:0] != 3'b011;
      case (f6)
        6'b000001: aluop = VALU_AND;
        6'b000010: aluop = VALU_OR;
        6'b000100: aluop = VALU_MINU;
        6'b000101: aluop = VALU_MIN;
        6'b000110: aluop = VALU_MAXU;
        6'b000111: aluop = VALU_MAX;
        default:   aluop = VALU_ADD;
      endcase
    end else if (is_opv && f3 == OPMVX && f6 == 6'b001111) begin
      // vslide1down
      aluop   = VALU_SLIDE;
      vs2_src = VS2_SRC_IDX_PLUS_1;
    end
  end

  // slide amounts are unsigned, arithmetic immediates are signed
  assign sign_imm = is_opv && f3 == OPIVI && aluop != VALU_SLIDE;

endmodule

`default_nettype wire

// File: hdl/vec_offset_gen.sv
/*
 * lane offset generator
 * forms the vd and vs2 element offsets of the current pair, the masked
 * write enables and the reduction identity value
 */
`default_nettype none

module vec_offset_gen
  import vec_decode_pkg::*;
(
  input  offset_t    offset,
  input  offset_t    vl,
  input  offset_t    vstart,
  input  word_t      xs1,
  input  logic [4:0] imm5,
  input  vs2_src_t   vs2_src,
  input  logic       vm,
  input  logic       is_store,
  input  logic       reduction,
  input  aluop_t     aluop,
  input  logic [1:0] mask_bits,
  output offset_t    woffset0,
  output offset_t    woffset1,
  output offset_t    vs2_offset0,
  output offset_t    vs2_offset1,
  output logic       wen0,
  output logic       wen1,
  output word_t      identity
);

  offset_t vs2_base;
  logic    lanes_ok;

  assign woffset0 = offset;
  assign woffset1 = offset + 32'd1;

  always_comb begin
    case (vs2_src)
      VS2_SRC_IDX_PLUS_RS1:  vs2_base = offset + xs1;
      VS2_SRC_IDX_PLUS_UIMM: vs2_base = offset + {27'd0, imm5};
      VS2_SRC_IDX_PLUS_1:    vs2_base = offset + 32'd1;
      default:               vs2_base = offset;
    endcase
  end

  // zero source reads the same element on both lanes
  assign vs2_offset0 = (vs2_src == VS2_SRC_ZERO) ? '0 : vs2_base;
  assign vs2_offset1 = (vs2_src == VS2_SRC_ZERO) ? '0 : vs2_base + 32'd1;

  // vm set means unmasked
  assign lanes_ok = vstart < vl && !is_store;
  assign wen0     = lanes_ok && woffset0 < vl && (vm || mask_bits[0]);
  assign wen1     = lanes_ok && woffset1 < vl && (vm || mask_bits[1]) && !reduction;

  // seed for the vs1 accumulator of a reduction
  always_comb begin
    identity = '0;
    if (reduction) begin
      case (aluop)
        VALU_AND,
        VALU_MINU: identity = 32'hffff_ffff;
        VALU_MIN:  identity = 32'h7fff_ffff;
        VALU_MAX:  identity = 32'h8000_0000;
        default:   identity = '0;
      endcase
    end
  end

endmodule

`default_nettype wire
